/* files.f */
+incdir+include
src/rtg_pkg.sv
src/rtg_stream_fetch.sv
src/rtg_pixel_timing.sv
src/rtg_pixel_output.sv
src/rtg_video_top.sv
verification/rtg_video_checker.sv
verification/tb_rtg_video.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
	--top-module tb_rtg_video -f files.f -o tb_rtg_video

./obj_dir/tb_rtg_video | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

/* verification/tb_rtg_video.sv */
// Synthetic frames of 10 lines of 80 clocks; memory data is a hash of the word address
`timescale 1ns/10ps
`default_nettype none

`include "rtg_params.svh"

module tb_rtg_video;
	import rtg_pkg::*;

	localparam int LINE_LEN = 80;   // Clocks per line
	localparam int ACTIVE   = 59;   // Clocks before hblank
	localparam int LINES    = 10;
	localparam int VB_LINES = 2;    // Chipset vblank lines
	localparam int FRAMES   = 16;   // Two per test
	localparam int MAX_CYC  = FRAMES * LINES * LINE_LEN + `RTG_CLUT_SIZE + 1000;

	logic        CLK_114;
	logic        rst_n;
	rtg_cfg_t    cfg;
	chip_video_t chip;
	clut_wr_t    clut_wr;
	osd_t        osd;
	mem_rsp_t    mem_rsp;
	mem_req_t    mem_req;
	rgb_t        vga_rgb;
	logic        vga_hs;
	logic        vga_vs;
	logic        underrun;
	logic        test_start;
	int          test_errors;
	int          total_errors;
	logic        underrun_seen;
	integer      seed = 32'h3705;
	integer      fill_seed = 32'h3705;  // Responder's own stream
	logic        hold_fills;            // Memory stalls
	logic        osd_on;
	logic        clut_writes;
	int          cycles;
	int          fill_k;                // Word of burst
	int          fill_wait;
	int          fail_count;
	int          test_count;
	rtg_cfg_t    c;

	rtg_video_top i_rtg_video_top (
		.CLK_114 (CLK_114), .rst_n (rst_n), .cfg (cfg), .chip (chip),
		.clut_wr (clut_wr), .osd (osd), .mem_rsp (mem_rsp), .mem_req (mem_req),
		.vga_rgb (vga_rgb), .vga_hs (vga_hs), .vga_vs (vga_vs), .underrun (underrun)
	);

	rtg_video_checker i_checker (
		.CLK_114 (CLK_114), .rst_n (rst_n), .cfg (cfg), .chip (chip),
		.clut_wr (clut_wr), .osd (osd), .mem_rsp (mem_rsp), .mem_req (mem_req),
		.vga_rgb (vga_rgb), .vga_hs (vga_hs), .vga_vs (vga_vs), .underrun (underrun),
		.test_start (test_start), .test_errors (test_errors),
		.total_errors (total_errors), .underrun_seen (underrun_seen)
	);

	function automatic logic [15:0] mem_word(input logic [`RTG_ADDR_W-1:0] a);
		logic [31:0] h;
		h = {7'h0, a} * 32'h9E37_79B1;
		h = h ^ (h >> 15);
		return h[15:0];
	endfunction

	function automatic rtg_cfg_t random_cfg(input rtg_mode_e mode, input logic ext);
		rtg_cfg_t r;
		r.ena         = 1'b1;
		r.mode        = mode;
		r.pixel_width = 4'(4 + ($random(seed) & 7));  // Slower than worst fill rate
		r.vb_end      = 7'(1 + ($random(seed) & 3));  // Time to prefill
		r.ext         = ext;
		r.base_addr   = 21'($random(seed));
		return r;
	endfunction

	initial begin
		CLK_114 = 1'b0;
		forever #50 CLK_114 = ~CLK_114;
	end

	//////////////////////////////
	// Run limit
	//////////////////////////////

	initial begin
		cycles = 0;
		while (cycles < MAX_CYC) begin
			@(posedge CLK_114);
			cycles = cycles + 1;
		end
		$display("Timeout: run stopped after %0d cycles", cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	//////////////////////////////
	// Memory responder
	//////////////////////////////

	initial begin
		mem_rsp = '0;
		fill_k = 0;
		fill_wait = 0;
		forever begin
			@(negedge CLK_114);
			if (!rst_n || !mem_req.req) begin
				mem_rsp.fill = 1'b0;                   // Burst done or abandoned
				fill_k       = 0;
				fill_wait    = $random(fill_seed) & 3;
			end else begin
				if (mem_rsp.fill)
					fill_k = fill_k + 1;               // Taken at last rising edge
				mem_rsp.fill = 1'b0;
				if (fill_k < `RTG_BURST_LEN && !hold_fills) begin
					if (fill_wait == 0) begin
						mem_rsp.fill = 1'b1;
						mem_rsp.data = mem_word(mem_req.addr + `RTG_ADDR_W'(fill_k));
						fill_wait    = $random(fill_seed) & 3;
					end else
						fill_wait = fill_wait - 1;
				end
			end
		end
	end

	//////////////////////////////
	// Frame stimulus
	//////////////////////////////

	task automatic fill_palette();
		int i;
		for (i = 0; i < `RTG_CLUT_SIZE; i++) begin
			@(negedge CLK_114);
			clut_wr.we  = 1'b1;
			clut_wr.idx = 8'(i);
			clut_wr.rgb = 24'($random(seed));
		end
		@(negedge CLK_114);
		clut_wr.we = 1'b0;
	endtask

	task automatic run_frame();
		int ln;
		int x;
		for (ln = 0; ln < LINES; ln++) begin
			for (x = 0; x < LINE_LEN; x++) begin
				@(negedge CLK_114);
				test_start  = 1'b0;
				chip.vblank = (ln < VB_LINES);
				chip.hblank = (x >= ACTIVE);
				chip.hsync  = (x >= ACTIVE + 6) && (x < ACTIVE + 14);
				chip.rgb    = 24'($random(seed));
				osd.window  = osd_on && (x >= 16) && (x < 40);
				osd.pixel   = 1'($random(seed));
				clut_wr.we  = clut_writes && (($random(seed) & 7) == 0);
				clut_wr.idx = 8'($random(seed));
				clut_wr.rgb = 24'($random(seed));
			end
		end
	endtask

	task automatic run_test(input string name, input rtg_cfg_t tc, input logic use_osd,
		input logic clut_rw, input logic hold, input logic exp_und);
		logic ok;
		@(negedge CLK_114);
		cfg         = tc;                              // Changed inside vblank
		osd_on      = use_osd;
		clut_writes = clut_rw;
		hold_fills  = hold;
		chip.vblank = 1'b1;
		osd.window  = 1'b0;
		clut_wr.we  = 1'b0;
		test_start  = 1'b1;
		run_frame();
		run_frame();
		repeat (2) @(negedge CLK_114);                 // Let the last outputs be compared
		ok = (test_errors == 0);
		if (underrun_seen != exp_und) begin
			$display("Test %s: underrun %s", name, exp_und ? "never rose" : "rose unexpectedly");
			ok = 1'b0;
		end
		test_count = test_count + 1;
		if (ok)
			$display("Test %0d %s: ok", test_count, name);
		else begin
			fail_count = fail_count + 1;
			$display("Test %0d %s: failed, %0d value errors", test_count, name, test_errors);
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		cfg         = '0;
		chip        = '0;
		chip.vblank = 1'b1;
		chip.hblank = 1'b1;
		clut_wr     = '0;
		osd         = '0;
		hold_fills  = 1'b0;
		osd_on      = 1'b0;
		clut_writes = 1'b0;
		test_start  = 1'b0;
		fail_count  = 0;
		test_count  = 0;
		repeat (10) @(negedge CLK_114);
		rst_n = 1'b1;
		fill_palette();

		c = random_cfg(MODE_HICOLOR, 1'b0);
		c.ena = 1'b0;
		run_test("pass-through", c, 1'b0, 1'b0, 1'b0, 1'b0);
		run_test("high-colour stream", random_cfg(MODE_HICOLOR, 1'b0), 1'b0, 1'b0, 1'b0, 1'b0);
		run_test("CLUT mode", random_cfg(MODE_CLUT, 1'b0), 1'b0, 1'b1, 1'b0, 1'b0);
		c = random_cfg(MODE_HICOLOR, 1'b1);
		c.vb_end = 7'(3 + ($random(seed) & 3));         // Longer extension
		c.pixel_width = 4'd5;                          // Strobe lands on first hblank clock
		run_test("extended vblank and ext", c, 1'b0, 1'b0, 1'b0, 1'b0);
		c = random_cfg(MODE_HICOLOR, 1'b1);
		c.pixel_width = 4'd4;                          // Fastest fetch rate
		run_test("back-pressure", c, 1'b0, 1'b0, 1'b0, 1'b0);
		run_test("underrun", random_cfg(MODE_HICOLOR, 1'b0), 1'b0, 1'b0, 1'b1, 1'b1);
		run_test("OSD over RTG", random_cfg(MODE_CLUT, 1'b0), 1'b1, 1'b0, 1'b0, 1'b0);
		c.ena = 1'b0;
		run_test("OSD over chipset", c, 1'b1, 1'b0, 1'b0, 1'b0);

		$display("Tests: %0d run, %0d failed, %0d value errors", test_count, fail_count,
			total_errors);
		if (fail_count == 0 && total_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/rtg_video_checker.sv */
// Cycle model of the RTG path; compares DUT outputs at each rising edge, palette must be written before use
`timescale 1ns/10ps
`default_nettype none

`include "rtg_params.svh"

module rtg_video_checker (
	input  logic                  CLK_114,
	input  logic                  rst_n,
	input  rtg_pkg::rtg_cfg_t     cfg,
	input  rtg_pkg::chip_video_t  chip,
	input  rtg_pkg::clut_wr_t     clut_wr,
	input  rtg_pkg::osd_t         osd,
	input  rtg_pkg::mem_rsp_t     mem_rsp,
	input  rtg_pkg::mem_req_t     mem_req,
	input  rtg_pkg::rgb_t         vga_rgb,
	input  logic                  vga_hs,
	input  logic                  vga_vs,
	input  logic                  underrun,
	input  logic                  test_start,    // Clears per-test counts
	output int                    test_errors,
	output int                    total_errors,
	output logic                  underrun_seen
);
	import rtg_pkg::*;

	rgb_t                   pal [`RTG_CLUT_SIZE];  // Palette copy
	logic [`RTG_DATA_W-1:0] fifo_q [$];            // Words fetched, not yet shown
	logic [`RTG_PW_W-1:0]   m_ctr;                 // Pixel counter
	logic                   m_sel;
	logic                   m_sel_d;
	logic                   m_blank_d;
	logic                   m_hs_d;
	logic                   m_vb_ext;
	logic [`RTG_VB_W-1:0]   m_lines;               // Lines since vblank fell
	logic                   m_busy;                // Burst outstanding
	logic [`RTG_ADDR_W-1:0] m_addr;
	int                     m_fills;
	logic [`RTG_DATA_W-1:0] m_word;
	logic                   m_und;
	rgb_t                   m_rgb;
	logic                   m_hs;
	logic                   m_vs;
	int                     errs;
	int                     cyc;
	logic                   blank;
	logic                   strobe;
	logic                   srst;
	logic                   room;
	logic                   empty;
	logic                   take;
	logic [7:0]             idx;
	rgb_t                   rtg_col;
	rgb_t                   col;

	// RGB555 field to 8 bits
	function automatic logic [7:0] widen5(input logic [4:0] c);
		return {c, c[4:2]};
	endfunction

	task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Fail %s expected %h actual %h at cycle %0d", sig, exp, act, cyc);
			errs = errs + 1;
		end
	endtask

	//////////////////////////////
	// Model and compare
	//////////////////////////////

	always @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			m_ctr <= '0;
			m_sel <= 1'b0;
			m_sel_d <= 1'b0;
			m_blank_d <= 1'b1;
			m_hs_d <= 1'b0;
			m_vb_ext <= 1'b1;                          // Blank until first vblank fall
			m_lines <= '0;
			m_busy <= 1'b0;
			m_addr <= '0;
			m_fills = 0;
			m_word <= '0;
			m_und <= 1'b0;
			m_rgb <= '0;
			m_hs <= 1'b0;
			m_vs <= 1'b0;
			fifo_q.delete();
			cyc = 0;
			test_errors <= 0;
			total_errors <= 0;
			underrun_seen <= 1'b0;
		end else begin
			// Outputs still hold last cycle's values here
			errs = 0;
			cyc  = cyc + 1;
			compare("vga_rgb", {8'h0, m_rgb}, {8'h0, vga_rgb});
			compare("vga_hs", {31'h0, m_hs}, {31'h0, vga_hs});
			compare("vga_vs", {31'h0, m_vs}, {31'h0, vga_vs});
			compare("mem_req.req", {31'h0, m_busy}, {31'h0, mem_req.req});
			if (m_busy)
				compare("mem_req.addr", {7'h0, m_addr}, {7'h0, mem_req.addr});
			compare("underrun", {31'h0, m_und}, {31'h0, underrun});
			test_errors  <= (test_start ? 0 : test_errors) + errs;
			total_errors <= total_errors + errs;

			// Pacing
			blank  = chip.hblank | m_vb_ext;
			strobe = cfg.ena & (~blank | (~m_blank_d & cfg.ext)) & (m_ctr == cfg.pixel_width);
			m_blank_d <= blank;
			m_sel_d   <= m_sel;
			m_hs_d    <= chip.hsync;
			if (blank || strobe) begin
				m_ctr <= '0;
				m_sel <= 1'b0;
			end else begin
				m_ctr <= m_ctr + 1'b1;
				if (m_ctr == (cfg.pixel_width >> 1))
					m_sel <= 1'b1;                     // Low byte from here
			end
			if (chip.vblank) begin
				m_vb_ext <= 1'b1;
				m_lines  <= '0;
			end else if (m_lines == cfg.vb_end)
				m_vb_ext <= 1'b0;
			else if (chip.hsync && !m_hs_d)
				m_lines <= m_lines + 1'b1;             // Rising hsync

			// Colour
			idx = m_sel_d ? m_word[7:0] : m_word[15:8];
			if (cfg.mode == MODE_CLUT)
				rtg_col = pal[idx];
			else begin
				rtg_col.r = widen5(m_word[14:10]);
				rtg_col.g = widen5(m_word[9:5]);
				rtg_col.b = widen5(m_word[4:0]);
			end
			col = (cfg.ena && !blank) ? rtg_col : chip.rgb;
			if (osd.window) begin
				col.r = {osd.pixel ? 2'b11 : 2'b00, col.r[7:2]};
				col.g = {osd.pixel ? 2'b11 : 2'b00, col.g[7:2]};
				col.b = {osd.pixel ? 2'b11 : 2'b10, col.b[7:2]};  // Blue tint
			end
			m_rgb <= col;
			m_hs  <= chip.hsync;
			m_vs  <= chip.vblank;
			if (clut_wr.we)
				pal[clut_wr.idx] = clut_wr.rgb;        // After the read, as in hardware

			if (test_start)
				underrun_seen <= 1'b0;
			else if (m_und)
				underrun_seen <= 1'b1;

			// Stream
			srst  = chip.vblank | ~cfg.ena;
			room  = fifo_q.size() <= (`RTG_FIFO_DEPTH - `RTG_BURST_LEN);
			empty = (fifo_q.size() == 0);
			take  = m_busy & mem_rsp.fill & ~srst;
			if (strobe) begin
				if (!srst && !empty)
					m_word <= fifo_q.pop_front();
				else
					m_word <= '0;                      // Starved or reset
			end
			if (srst) begin
				fifo_q.delete();
				m_und   <= 1'b0;
				m_busy  <= 1'b0;
				m_addr  <= {cfg.base_addr, 4'h0};
				m_fills = 0;
			end else begin
				if (strobe && empty)
					m_und <= 1'b1;
				if (take) begin
					fifo_q.push_back(mem_rsp.data);
					m_fills = m_fills + 1;
					if (m_fills == `RTG_BURST_LEN) begin
						m_busy  <= 1'b0;
						m_addr  <= m_addr + `RTG_ADDR_W'(`RTG_BURST_LEN);
						m_fills = 0;
					end
				end else if (!m_busy && room)
					m_busy <= 1'b1;                    // Burst fits
			end
		end
	end

endmodule

`default_nettype wire

/* src/rtg_video_top.sv */
// Single clock domain; memory port uses the req/fill burst handshake, not a standard bus
`timescale 1ns/10ps
`default_nettype none

`include "rtg_params.svh"

module rtg_video_top (
	input  logic                    CLK_114,
	input  logic                    rst_n,
	input  rtg_pkg::rtg_cfg_t       cfg,
	input  rtg_pkg::chip_video_t    chip,     // Chipset video in
	input  rtg_pkg::clut_wr_t       clut_wr,  // Palette write port
	input  rtg_pkg::osd_t           osd,
	input  rtg_pkg::mem_rsp_t       mem_rsp,
	output rtg_pkg::mem_req_t       mem_req,
	output rtg_pkg::rgb_t           vga_rgb,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic                    underrun  // FIFO ran dry
);

	logic                   pixel_strobe;     // Timing to fetcher
	logic                   byte_sel;         // Timing to output
	logic                   blank;            // Timing to output
	logic [`RTG_DATA_W-1:0] word;             // Fetcher to output

	//////////////////////////////
	// Pipeline stages
	//////////////////////////////

	rtg_pixel_timing i_pixel_timing (
		.CLK_114      (CLK_114),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.chip         (chip),
		.pixel_strobe (pixel_strobe),
		.byte_sel     (byte_sel),
		.blank        (blank)
	);

	rtg_stream_fetch i_stream_fetch (
		.CLK_114      (CLK_114),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.vblank       (chip.vblank),      // Stream restarts each frame
		.pixel_strobe (pixel_strobe),
		.mem_req      (mem_req),
		.mem_rsp      (mem_rsp),
		.word         (word),
		.underrun     (underrun)
	);

	rtg_pixel_output i_pixel_output (
		.CLK_114      (CLK_114),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.chip         (chip),
		.blank        (blank),
		.byte_sel     (byte_sel),
		.word         (word),
		.clut_wr      (clut_wr),
		.osd          (osd),
		.vga_rgb      (vga_rgb),
		.vga_hs       (vga_hs),
		.vga_vs       (vga_vs)
	);

endmodule

`default_nettype wire

/* src/rtg_pixel_output.sv */
// Palette is undefined until written and has no reset; vga_vs carries the registered chipset vblank
`timescale 1ns/10ps
`default_nettype none

`include "rtg_params.svh"

module rtg_pixel_output (
	input  logic                    CLK_114,
	input  logic                    rst_n,
	input  rtg_pkg::rtg_cfg_t       cfg,
	input  rtg_pkg::chip_video_t    chip,
	input  logic                    blank,
	input  logic                    byte_sel, // 0 high byte, 1 low byte
	input  logic [`RTG_DATA_W-1:0]  word,
	input  rtg_pkg::clut_wr_t       clut_wr,
	input  rtg_pkg::osd_t           osd,
	output rtg_pkg::rgb_t           vga_rgb,
	output logic                    vga_hs,
	output logic                    vga_vs
);
	import rtg_pkg::*;

	rgb_t       clut_mem [`RTG_CLUT_SIZE];
	logic [7:0] clut_idx;
	rgb_t       hi_rgb;    // RGB555 expanded
	rgb_t       clut_rgb;  // Palette entry
	rgb_t       rtg_rgb;
	rgb_t       mux_rgb;   // RTG or chipset
	rgb_t       osd_rgb;   // After overlay
	logic [1:0] osd_r;
	logic [1:0] osd_g;
	logic [1:0] osd_b;

	// 5 bits on top, upper 3 repeated below
	function automatic logic [7:0] expand5(input logic [4:0] c);
		return {c, c[4:2]};
	endfunction

	// OSD bits on top, colour shifted down
	function automatic logic [7:0] overlay(input logic [1:0] top, input logic [7:0] c);
		return {top, c[7:2]};
	endfunction

	//////////////////////////////
	// Palette memory
	//////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (clut_wr.we)
			clut_mem[clut_wr.idx] <= clut_wr.rgb;
	end

	assign clut_idx = byte_sel ? word[7:0] : word[15:8];
	assign clut_rgb = clut_mem[clut_idx];                 // Asynchronous read

	//////////////////////////////
	// Colour decode and select
	//////////////////////////////

	assign hi_rgb.r = expand5(word[14:10]);               // Bit 15 unused
	assign hi_rgb.g = expand5(word[9:5]);
	assign hi_rgb.b = expand5(word[4:0]);

	assign rtg_rgb = (cfg.mode == MODE_CLUT) ? clut_rgb : hi_rgb;
	assign mux_rgb = (cfg.ena && !blank) ? rtg_rgb : chip.rgb;

	// Blue tint behind OSD text
	assign osd_r = osd.pixel ? 2'b11 : 2'b00;
	assign osd_g = osd.pixel ? 2'b11 : 2'b00;
	assign osd_b = osd.pixel ? 2'b11 : 2'b10;

	always_comb begin
		osd_rgb = mux_rgb;
		if (osd.window) begin
			osd_rgb.r = overlay(osd_r, mux_rgb.r);
			osd_rgb.g = overlay(osd_g, mux_rgb.g);
			osd_rgb.b = overlay(osd_b, mux_rgb.b);
		end
	end

	//////////////////////////////
	// Output register
	//////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			vga_rgb <= '0;
			vga_hs  <= 1'b0;
			vga_vs  <= 1'b0;
		end else begin
			vga_rgb <= osd_rgb;
			vga_hs  <= chip.hsync;                        // Same delay as colour
			vga_vs  <= chip.vblank;
		end
	end

endmodule

`default_nettype wire

/* src/rtg_pixel_timing.sv */
// Chipset blank and sync inputs must already be synchronous to CLK_114; vb_end counts hsync rising edges
`timescale 1ns/10ps
`default_nettype none

`include "rtg_params.svh"

module rtg_pixel_timing (
	input  logic                    CLK_114,
	input  logic                    rst_n,
	input  rtg_pkg::rtg_cfg_t       cfg,
	input  rtg_pkg::chip_video_t    chip,
	output logic                    pixel_strobe, // Fetch next word
	output logic                    byte_sel,     // Delayed low byte select
	output logic                    blank         // RTG blanked
);

	logic [`RTG_PW_W-1:0] pix_ctr;  // Clocks since last fetch
	logic                 sel;      // Low byte flag
	logic                 sel_d;
	logic                 blank_d;  // Blank one cycle back
	logic                 hs_d;
	logic                 hs_rise;
	logic                 vb_ext;   // Extended vblank
	logic [`RTG_VB_W-1:0] vb_ctr;   // Lines since vblank fell

	assign blank    = chip.hblank | vb_ext;
	assign hs_rise  = chip.hsync & ~hs_d;
	assign byte_sel = sel_d;

	// Fetch also one step past the start of blank when ext is set
	assign pixel_strobe = cfg.ena & (~blank | (~blank_d & cfg.ext))
		& (pix_ctr == cfg.pixel_width);

	//////////////////////////////
	// Fetch pacing
	//////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			pix_ctr <= '0;
			sel     <= 1'b0;
			sel_d   <= 1'b0;
			blank_d <= 1'b1;
		end else begin
			blank_d <= blank;
			sel_d   <= sel;
			if (blank || pixel_strobe) begin
				pix_ctr <= '0;                            // Restart word
				sel     <= 1'b0;                          // Back to high byte
			end else begin
				pix_ctr <= pix_ctr + 1'b1;
				if (pix_ctr == (cfg.pixel_width >> 1))
					sel <= 1'b1;                          // Half way through word
			end
		end
	end

	//////////////////////////////
	// Extended vblank
	//////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			hs_d   <= 1'b0;
			vb_ext <= 1'b1;                               // Blank until first vblank fall
			vb_ctr <= '0;
		end else begin
			hs_d <= chip.hsync;
			if (chip.vblank) begin
				vb_ext <= 1'b1;
				vb_ctr <= '0;
			end else if (vb_ctr == cfg.vb_end) begin
				vb_ext <= 1'b0;                           // Counter parks here
			end else if (hs_rise) begin
				vb_ctr <= vb_ctr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/rtg_stream_fetch.sv */
// Memory must deliver exactly RTG_BURST_LEN fills per request; address after power-up reset is 0 until the first stream reset
`timescale 1ns/10ps
`default_nettype none

`include "rtg_params.svh"

module rtg_stream_fetch (
	input  logic                    CLK_114,
	input  logic                    rst_n,
	input  rtg_pkg::rtg_cfg_t       cfg,
	input  logic                    vblank,       // Chipset vblank
	input  logic                    pixel_strobe, // Pop request
	output rtg_pkg::mem_req_t       mem_req,
	input  rtg_pkg::mem_rsp_t       mem_rsp,
	output logic [`RTG_DATA_W-1:0]  word,         // Last popped word
	output logic                    underrun      // Sticky until stream reset
);
	import rtg_pkg::*;

	localparam int PTR_W  = $clog2(`RTG_FIFO_DEPTH);
	localparam int LVL_W  = PTR_W + 1;
	localparam int BCNT_W = $clog2(`RTG_BURST_LEN);

	fetch_state_e            state;
	logic [`RTG_ADDR_W-1:0]  addr;                         // Next burst start
	logic [BCNT_W-1:0]       fill_cnt;                     // Words of current burst
	logic [`RTG_DATA_W-1:0]  fifo_mem [`RTG_FIFO_DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [LVL_W-1:0]        level;                        // Words held
	logic                    stream_rst;
	logic                    fill_ok;
	logic                    pop_ok;
	logic                    starve;
	logic                    room;

	assign stream_rst = vblank | ~cfg.ena;                     // Restart every frame
	assign fill_ok    = (state == FETCH_BURST) & mem_rsp.fill & ~stream_rst;
	assign pop_ok     = pixel_strobe & (level != '0) & ~stream_rst;
	assign starve     = pixel_strobe & (level == '0) & ~stream_rst;
	assign room       = level <= LVL_W'(`RTG_FIFO_DEPTH - `RTG_BURST_LEN); // Whole burst fits

	assign mem_req.req  = (state == FETCH_BURST);
	assign mem_req.addr = addr;

	//////////////////////////////
	// Burst request FSM
	//////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			state    <= FETCH_IDLE;
			addr     <= '0;
			fill_cnt <= '0;
		end else if (stream_rst) begin
			state    <= FETCH_IDLE;                       // Drops req next cycle
			addr     <= {cfg.base_addr, 4'h0};
			fill_cnt <= '0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (room)
						state <= FETCH_BURST;             // Raise req
				end
				FETCH_BURST: begin
					if (fill_ok) begin
						fill_cnt <= fill_cnt + 1'b1;      // Wraps at burst end
						if (fill_cnt == BCNT_W'(`RTG_BURST_LEN - 1)) begin
							state <= FETCH_IDLE;
							addr  <= addr + `RTG_ADDR_W'(`RTG_BURST_LEN);
						end
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Circular FIFO
	//////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (fill_ok)
			fifo_mem[wr_ptr] <= mem_rsp.data;
	end

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else if (stream_rst) begin
			wr_ptr <= '0;                                 // Flush
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (fill_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({fill_ok, pop_ok})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;                  // Both or neither
			endcase
		end
	end

	//////////////////////////////
	// Pop register
	//////////////////////////////

	always_ff @(posedge CLK_114 or negedge rst_n) begin
		if (!rst_n) begin
			word     <= '0;
			underrun <= 1'b0;
		end else begin
			if (pixel_strobe)
				word <= pop_ok ? fifo_mem[rd_ptr] : '0;    // Empty gives zero
			if (stream_rst)
				underrun <= 1'b0;
			else if (starve)
				underrun <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/rtg_pkg.sv */
// Shared types for the RTG path; base_addr is in 16-word units so the low 4 address bits are zero
`default_nettype none

`include "rtg_params.svh"

package rtg_pkg;

	//////////////////////////////
	// Colour and mode
	//////////////////////////////

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef enum logic {
		MODE_HICOLOR = 1'b0, // RGB555 words
		MODE_CLUT    = 1'b1  // Two 8-bit indices per word
	} rtg_mode_e;

	typedef struct packed {
		logic                     ena;         // RTG screen on
		rtg_mode_e                mode;
		logic [`RTG_PW_W-1:0]     pixel_width; // Clocks per fetch minus one
		logic [`RTG_VB_W-1:0]     vb_end;      // Extra blank lines after vblank
		logic                     ext;         // One more fetch into hblank
		logic [`RTG_ADDR_W-5:0]   base_addr;   // Upper address bits
	} rtg_cfg_t;

	//////////////////////////////
	// Memory handshake
	//////////////////////////////

	typedef struct packed {
		logic                     req;  // Held for the whole burst
		logic [`RTG_ADDR_W-1:0]   addr; // First word of burst
	} mem_req_t;

	typedef struct packed {
		logic                     fill; // One pulse per word
		logic [`RTG_DATA_W-1:0]   data;
	} mem_rsp_t;

	//////////////////////////////
	// Video side
	//////////////////////////////

	typedef struct packed {
		logic hblank;
		logic vblank; // Also used as the vsync source
		logic hsync;
		rgb_t rgb;    // Chipset colour
	} chip_video_t;

	typedef struct packed {
		logic       we;
		logic [7:0] idx;
		rgb_t       rgb;
	} clut_wr_t;

	typedef struct packed {
		logic window; // Inside OSD area
		logic pixel;  // OSD foreground
	} osd_t;

	typedef enum logic {
		FETCH_IDLE  = 1'b0,
		FETCH_BURST = 1'b1
	} fetch_state_e;

endpackage

`default_nettype wire

/* include/rtg_params.svh */
// Widths assume 16-bit frame buffer words and a burst length that divides the FIFO depth
`ifndef RTG_PARAMS_SVH
`define RTG_PARAMS_SVH

//////////////////////////////
// Memory port
//////////////////////////////

`define RTG_ADDR_W     25  // Word address bits
`define RTG_DATA_W     16  // Frame buffer word
`define RTG_BURST_LEN  4   // Fill pulses per request

//////////////////////////////
// Stream and palette
//////////////////////////////

`define RTG_FIFO_DEPTH 16  // Power of two for pointer wrap
`define RTG_CLUT_SIZE  256 // One entry per 8-bit index

//////////////////////////////
// Config fields
//////////////////////////////

`define RTG_PW_W       4   // Clocks per fetch minus one
`define RTG_VB_W       7   // Extra vblank lines

`endif
